/* verilog/dpa_pkg.sv */
package dpa_pkg;

    localparam int N_INT  = 8;
    localparam int N_MANT = 7;
    localparam int N_TOT  = N_INT + N_MANT;  // width less the sign bit

    typedef logic signed [N_TOT:0] fix_t;  // Q8.7

    localparam int N_TAPS      = 16;
    localparam int LUT_BITS    = 4;
    localparam int N_LANES     = N_TAPS / LUT_BITS;
    localparam int TREE_STAGES = 2;

    typedef logic [N_TAPS-1:0]   sel_t;
    typedef logic [LUT_BITS-1:0] lane_sel_t;

    // every magnitude stays below 2**11 so the full sum fits in Q8.7
    localparam fix_t WEIGHTS [N_TAPS] = '{
         16'sd192,  -16'sd320,   16'sd96,    16'sd1000,
        -16'sd1500,  16'sd640,   16'sd45,   -16'sd77,
         16'sd1280, -16'sd256,   16'sd512,  -16'sd1024,
         16'sd300,   16'sd2000, -16'sd1999,  16'sd7
    };

    typedef enum logic [1:0] {
        CAP_IDLE,  // waiting for req
        CAP_ACK,   // word taken, ack held high
        CAP_DROP   // req gone, ack dropped
    } cap_state_e;

endpackage

/* verilog/dpa_lane_if.sv */
interface dpa_lane_if;

    logic               load;           // one-cycle capture pulse
    dpa_pkg::lane_sel_t sel_slice;      // 4-bit slice for this lane
    dpa_pkg::fix_t      partial;        // looked-up partial sum
    logic               partial_valid;

    modport feed (
        output load,
        output sel_slice
    );

    modport lane (
        input  load,
        input  sel_slice,
        output partial,
        output partial_valid
    );

    modport drain (
        input partial,
        input partial_valid
    );

endinterface

/* verilog/sel_capture.sv */
module sel_capture (
    input  logic          clk,
    input  logic          rst,
    input  logic          req,
    input  dpa_pkg::sel_t sel,
    output logic          ack,
    dpa_lane_if.feed      lanes [dpa_pkg::N_LANES]
);

    dpa_pkg::cap_state_e state;
    dpa_pkg::cap_state_e state_nxt;
    dpa_pkg::sel_t       sel_q;
    logic                load;
    logic                accept;

    assign accept = (state == dpa_pkg::CAP_IDLE) && req;

    always_comb begin
        state_nxt = state;
        case (state)
            dpa_pkg::CAP_IDLE: begin
                if (req) begin
                    state_nxt = dpa_pkg::CAP_ACK;
                end
            end
            dpa_pkg::CAP_ACK: begin
                if (!req) begin  // held req gives no second capture
                    state_nxt = dpa_pkg::CAP_DROP;
                end
            end
            dpa_pkg::CAP_DROP: begin
                state_nxt = dpa_pkg::CAP_IDLE;  // one idle gap before next word
            end
            default: begin
                state_nxt = dpa_pkg::CAP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dpa_pkg::CAP_IDLE;
            load  <= 1'b0;
        end else begin
            state <= state_nxt;
            load  <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sel_q <= sel;
        end
    end

    assign ack = (state == dpa_pkg::CAP_ACK);

    // bit slice i of the word goes to lane i
    for (genvar i = 0; i < dpa_pkg::N_LANES; i++) begin : g_feed
        assign lanes[i].load      = load;
        assign lanes[i].sel_slice = sel_q[i*dpa_pkg::LUT_BITS +: dpa_pkg::LUT_BITS];
    end

    a_load_on_ack_rise : assert property (
        @(posedge clk) disable iff (rst)
        load == $rose(ack)
    ) else $error("load pulse not aligned with rising ack");

    a_no_rise_from_drop : assert property (
        @(posedge clk) disable iff (rst)
        $rose(ack) |-> ($past(state) != dpa_pkg::CAP_DROP) && $past(req)
    ) else $error("ack rose while in CAP_DROP");

endmodule

/* verilog/dpa_lut_lane.sv */
module dpa_lut_lane #(
    parameter int LANE = 0
) (
    input  logic     clk,
    input  logic     rst,
    dpa_lane_if.lane bus
);

    localparam int LUT_DEPTH = 2 ** dpa_pkg::LUT_BITS;

    typedef dpa_pkg::fix_t lut_t [LUT_DEPTH];

    if (LANE >= dpa_pkg::N_LANES) begin : g_bad_lane
        $error("lane index out of range");
    end

    // entry k adds weight j where bit j of k is set and subtracts it otherwise
    function automatic lut_t build_lut();
        lut_t          tbl;
        dpa_pkg::fix_t acc;
        dpa_pkg::fix_t w;
        for (int k = 0; k < LUT_DEPTH; k++) begin
            acc = '0;
            for (int j = 0; j < dpa_pkg::LUT_BITS; j++) begin
                w = dpa_pkg::WEIGHTS[LANE*dpa_pkg::LUT_BITS + j];
                if (k[j]) begin
                    acc = acc + w;
                end else begin
                    acc = acc - w;
                end
            end
            tbl[k] = acc;
        end
        return tbl;
    endfunction

    localparam lut_t LUT = build_lut();

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.partial_valid <= 1'b0;
        end else begin
            bus.partial_valid <= bus.load;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.load) begin
            bus.partial <= LUT[bus.sel_slice];  // held until next load
        end
    end

    // also catches a front end that repeats load on consecutive cycles
    a_valid_follows_load : assert property (
        @(posedge clk) disable iff (rst)
        bus.load |=> bus.partial_valid ##1 !bus.partial_valid
    ) else $error("partial_valid does not follow load by one cycle");

endmodule

/* verilog/partial_sum_tree.sv */
module partial_sum_tree (
    input  logic          clk,
    input  logic          rst,
    dpa_lane_if.drain     lanes [dpa_pkg::N_LANES],
    output dpa_pkg::fix_t result,
    output logic          result_valid
);

    dpa_pkg::fix_t                    lvl1_lo;
    dpa_pkg::fix_t                    lvl1_hi;
    logic [dpa_pkg::TREE_STAGES-1:0] vld_sr;

    // first level, lanes 0+1 and 2+3
    always_ff @(posedge clk) begin
        if (lanes[0].partial_valid) begin
            lvl1_lo <= lanes[0].partial + lanes[1].partial;
            lvl1_hi <= lanes[2].partial + lanes[3].partial;
        end
    end

    // second level
    always_ff @(posedge clk) begin
        if (vld_sr[0]) begin
            result <= lvl1_lo + lvl1_hi;  // weights keep this in range
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[dpa_pkg::TREE_STAGES-2:0], lanes[0].partial_valid};
        end
    end

    assign result_valid = vld_sr[dpa_pkg::TREE_STAGES-1];

    // lane 0 paces the tree, so the others must line up with it
    for (genvar i = 1; i < dpa_pkg::N_LANES; i++) begin : g_align
        a_lanes_aligned : assert property (
            @(posedge clk) disable iff (rst)
            lanes[i].partial_valid == lanes[0].partial_valid
        ) else $error("lane %0d out of step with lane 0", i);
    end

endmodule

/* verilog/dpa_top.sv */
module dpa_top (
    input  logic          clk,
    input  logic          rst,
    input  logic          req,
    input  dpa_pkg::sel_t sel,
    output logic          ack,
    output dpa_pkg::fix_t result,
    output logic          result_valid
);

    dpa_lane_if lane_bus [dpa_pkg::N_LANES] ();

    sel_capture i_capture (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .sel   (sel),
        .ack   (ack),
        .lanes (lane_bus)
    );

    for (genvar i = 0; i < dpa_pkg::N_LANES; i++) begin : g_lane
        dpa_lut_lane #(
            .LANE (i)
        ) i_lane (
            .clk (clk),
            .rst (rst),
            .bus (lane_bus[i])
        );
    end

    partial_sum_tree i_tree (
        .clk          (clk),
        .rst          (rst),
        .lanes        (lane_bus),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* tests/dpa_tb.sv */
module dpa_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD_NS = 8;
    localparam int RESET_CYCLES  = 8;
    localparam int IDLE_CHECKS   = 4;   // cycles watched after reset, before first req
    localparam int N_FIXED       = 2;
    localparam int N_WALK        = 2 * dpa_pkg::N_TAPS;
    localparam int N_RANDOM      = 200;
    localparam int N_TXN         = N_FIXED + N_WALK + N_RANDOM;
    localparam int CYC_PER_TXN   = 12;
    localparam int DRAIN_CYCLES  = 8;
    localparam int RESULT_LAT    = 3;   // ack rise to result_valid
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + IDLE_CHECKS + CYC_PER_TXN * N_TXN + DRAIN_CYCLES + 16;

    logic          clk;
    logic          rst;
    logic          req;
    dpa_pkg::sel_t sel;
    logic          ack;
    dpa_pkg::fix_t result;
    logic          result_valid;

    dpa_pkg::fix_t exp_q [$];   // expected results in issue order
    dpa_pkg::fix_t last_result;
    logic          have_result;
    logic          ack_prev;
    int            cyc;
    int            ack_rise_cyc;
    int            n_sent;
    int            n_results;
    int            n_ack_rises;
    integer        seed;

    dpa_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .sel          (sel),
        .ack          (ack),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) clk = ~clk;
    end

    // each weight counts positive where its bit is set, negative where it is clear
    function automatic dpa_pkg::fix_t ref_dot(input dpa_pkg::sel_t word);
        dpa_pkg::fix_t acc;
        acc = '0;
        for (int i = 0; i < dpa_pkg::N_TAPS; i++) begin
            if (word[i]) begin
                acc = acc + dpa_pkg::WEIGHTS[i];
            end else begin
                acc = acc - dpa_pkg::WEIGHTS[i];
            end
        end
        return acc;
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_result(input dpa_pkg::fix_t got, input dpa_pkg::fix_t expected,
                                input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0d ns: %s, got %0d (0x%h) expected %0d (0x%h)",
                     $time, what, got, got, expected, expected);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("MISMATCH at %0d ns: %s, got %b expected %b",
                     $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic check_latency(input int got, input int expected, input string what);
        if (got != expected) begin
            $display("MISMATCH at %0d ns: %s, got %0d cycles expected %0d",
                     $time, what, got, expected);
            abort_run();
        end
    endtask

    // called right after a rising edge, returns right after one
    task automatic send_word(input dpa_pkg::sel_t word, input int hold);
        req <= 1'b1;
        sel <= word;
        forever begin
            @(posedge clk);
            if (ack) begin
                break;
            end
        end
        exp_q.push_back(ref_dot(word));
        n_sent++;
        repeat (hold) begin  // req kept high past ack
            @(posedge clk);
            check_bit(ack, 1'b1, "ack while req still high");
        end
        req <= 1'b0;
        @(posedge clk);
        check_bit(ack, 1'b1, "ack in the cycle req drops");
        @(posedge clk);
        check_bit(ack, 1'b0, "ack after req dropped");
    endtask

    // compares every result against the queue and checks its timing
    always @(posedge clk) begin : compare_results
        dpa_pkg::fix_t expected;
        cyc = cyc + 1;
        if (!rst) begin
            if (ack && !ack_prev) begin
                ack_rise_cyc = cyc;
                n_ack_rises++;
            end
            if (result_valid) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR at %0d ns: result_valid with no word pending", $time);
                    abort_run();
                end else begin
                    expected = exp_q.pop_front();
                    check_result(result, expected, "dot product");
                    check_latency(cyc - ack_rise_cyc, RESULT_LAT,
                                  "result_valid after ack rise");
                    n_results++;
                    last_result = result;
                    have_result = 1'b1;
                end
            end else if (have_result) begin
                check_result(result, last_result, "result held between results");
            end
        end
        ack_prev = ack;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD_NS);
        $display("ERROR: watchdog expired, the run did not finish within %0d cycles",
                 WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        dpa_pkg::sel_t word;
        int            n;
        rst          = 1'b1;
        req          = 1'b0;
        sel          = '0;
        seed         = 32'h8a9712f4;
        cyc          = 0;
        ack_rise_cyc = 0;
        ack_prev     = 1'b0;
        have_result  = 1'b0;
        last_result  = '0;
        n_sent       = 0;
        n_results    = 0;
        n_ack_rises  = 0;
        n            = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // nothing may happen before the first req
        repeat (IDLE_CHECKS) begin
            @(posedge clk);
            check_bit(ack, 1'b0, "ack idle after reset");
            check_bit(result_valid, 1'b0, "result_valid idle after reset");
        end

        send_word('1, n % 4);  // sum of all weights
        n++;
        send_word('0, n % 4);  // its negative
        n++;

        for (int i = 0; i < dpa_pkg::N_TAPS; i++) begin
            word = '0;
            word[i] = 1'b1;
            send_word(word, n % 4);
            n++;
            send_word(~word, n % 4);
            n++;
        end

        for (int i = 0; i < N_RANDOM; i++) begin
            word = dpa_pkg::sel_t'($random(seed));
            send_word(word, n % 4);
            n++;
        end

        repeat (DRAIN_CYCLES) @(posedge clk);

        if (exp_q.size() != 0 || n_results != n_sent || n_ack_rises != n_sent) begin
            $display("ERROR: %0d words sent but %0d results and %0d ack pulses seen",
                     n_sent, n_results, n_ack_rises);
            abort_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* list.f */
verilog/dpa_pkg.sv
verilog/dpa_lane_if.sv
verilog/sel_capture.sv
verilog/dpa_lut_lane.sv
verilog/partial_sum_tree.sv
verilog/dpa_top.sv
tests/dpa_tb.sv

/* Bender.yml */
package:
  name: dpa

sources:
  # design, in compile order
  - verilog/dpa_pkg.sv
  - verilog/dpa_lane_if.sv
  - verilog/sel_capture.sv
  - verilog/dpa_lut_lane.sv
  - verilog/partial_sum_tree.sv
  - verilog/dpa_top.sv

  # testbench
  - target: test
    files:
      - tests/dpa_tb.sv
